//--- hw/cpu_pkg.sv
/*
 * Shared definitions of the reduced 6502-style core.
 * Sequencer states, ALU operations, register selects, the opcode
 * views and the fixed addresses and opcodes.
 */
package cpu_pkg;

    typedef enum logic [3:0] {
        RST0   = 4'd0,                      // Vector low byte on the bus
        RST1   = 4'd1,                      // Vector high byte on the bus
        DECODE = 4'd2,                      // Opcode fetch, previous result written
        OPER   = 4'd3,                      // Opcode arrives, operand fetch
        ZPRD   = 4'd4,                      // Zero-page data read
        ZPWR   = 4'd5,                      // Zero-page write
        JMP1   = 4'd6,                      // Jump high byte fetch
        BRA1   = 4'd7                       // Taken branch, offset added
    } state_t;

    typedef enum logic [2:0] {
        ALU_OR   = 3'd0,
        ALU_AND  = 3'd1,
        ALU_EOR  = 3'd2,
        ALU_ADD  = 3'd3,
        ALU_SUB  = 3'd4,                    // Add of inverted B
        ALU_PASS = 3'd5                     // A operand straight through
    } alu_op_t;

    typedef enum logic [1:0] {
        SEL_A = 2'd0,
        SEL_X = 2'd1,
        SEL_Y = 2'd2
    } reg_sel_t;

    // One byte, seen whole or split into the aaa/bbb/cc opcode matrix
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] aaa;                // Operation or branch condition
            logic [2:0] bbb;                // Addressing mode
            logic [1:0] cc;                 // Group
        } f;
    } opcode_u;

    localparam logic [1:0]  CI_ZERO      = 2'd0;
    localparam logic [1:0]  CI_ONE       = 2'd1;
    localparam logic [1:0]  CI_CARRY     = 2'd2;

    localparam logic [15:0] VEC_RESET_LO = 16'hfffc;
    localparam logic [15:0] VEC_RESET_HI = 16'hfffd;
    localparam logic [7:0]  ZEROPAGE     = 8'h00;

    localparam logic [7:0]  OPC_JMP      = 8'h4c;
    localparam logic [7:0]  OPC_CLC      = 8'h18;
    localparam logic [7:0]  OPC_SEC      = 8'h38;
    localparam logic [7:0]  OPC_INX      = 8'he8;
    localparam logic [7:0]  OPC_INY      = 8'hc8;
    localparam logic [7:0]  OPC_DEX      = 8'hca;
    localparam logic [7:0]  OPC_DEY      = 8'h88;
    localparam logic [7:0]  OPC_TAX      = 8'haa;
    localparam logic [7:0]  OPC_TXA      = 8'h8a;
    localparam logic [7:0]  OPC_TAY      = 8'ha8;
    localparam logic [7:0]  OPC_TYA      = 8'h98;

endpackage

//--- hw/cpu_decode.sv
/*
 * Instruction decoder and sequencer.
 * The opcode arrives on the read bus in OPER, where it picks the next
 * state and loads the control flops used up to the following DECODE.
 */
`timescale 1ns/10ps

module cpu_decode (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        rdata,
    input  logic              cond_true,
    output cpu_pkg::state_t   state,
    output cpu_pkg::alu_op_t  alu_op,
    output cpu_pkg::reg_sel_t src_sel,
    output cpu_pkg::reg_sel_t dst_sel,
    output logic              load_reg,
    output logic              mem_src,
    output logic              a_zero,
    output logic [1:0]        ci_mode,
    output logic              set_nz,
    output logic              set_c,
    output logic              set_v,
    output logic              clc,
    output logic              sec,
    output logic              is_store,
    output logic [2:0]        cond_code
);

    cpu_pkg::opcode_u opc;                  // Opcode on the read bus
    cpu_pkg::opcode_u ir;                   // Held for the branch cycle
    logic exec;                             // Write-back cycle
    logic zp;
    logic imm;
    logic ld;                               // LDA, LDX, LDY
    logic st;                               // STA, STX, STY
    logic alu;                              // ORA .. SBC group
    logic cmp;
    logic cpxy;
    logic adc_sbc;
    logic branch;
    logic inc;
    logic dec;
    logic xfer;                             // TAX, TXA, TAY, TYA
    logic load_d;
    logic load_q;
    logic nz_q;
    logic c_q;
    logic v_q;
    logic clc_q;
    logic sec_q;

    // Register named by the group bits of a load or store
    function automatic cpu_pkg::reg_sel_t grp_sel(input logic [1:0] cc);
        case (cc)
            2'b10:   grp_sel = cpu_pkg::SEL_X;
            2'b00:   grp_sel = cpu_pkg::SEL_Y;
            default: grp_sel = cpu_pkg::SEL_A;
        endcase
    endfunction

    assign opc.raw = rdata;
    assign exec    = (state == cpu_pkg::DECODE);

    assign zp      = (opc.f.bbb == 3'b001);
    assign imm     = (opc.f.cc == 2'b01) ? (opc.f.bbb == 3'b010) : (opc.f.bbb == 3'b000);
    assign ld      = (opc.f.aaa == 3'b101) && (zp || imm) && (opc.f.cc != 2'b11);
    assign st      = (opc.f.aaa == 3'b100) && zp && (opc.f.cc != 2'b11);
    assign alu     = (opc.f.cc == 2'b01) && (zp || imm) && (opc.f.aaa[2:1] != 2'b10);
    assign cmp     = alu && (opc.f.aaa == 3'b110);
    assign adc_sbc = alu && (opc.f.aaa[1:0] == 2'b11);
    assign cpxy    = (opc.f.cc == 2'b00) && (opc.f.aaa[2:1] == 2'b11) && imm;
    assign branch  = (opc.f.cc == 2'b00) && (opc.f.bbb == 3'b100);
    assign inc     = (opc.raw == cpu_pkg::OPC_INX) || (opc.raw == cpu_pkg::OPC_INY);
    assign dec     = (opc.raw == cpu_pkg::OPC_DEX) || (opc.raw == cpu_pkg::OPC_DEY);
    assign xfer    = (opc.raw == cpu_pkg::OPC_TAX) || (opc.raw == cpu_pkg::OPC_TXA) ||
                     (opc.raw == cpu_pkg::OPC_TAY) || (opc.raw == cpu_pkg::OPC_TYA);
    assign load_d  = ld || (alu && !cmp) || inc || dec || xfer;

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::OPER)
            ir <= opc;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_q   <= 1'b0;
            is_store <= 1'b0;
            dst_sel  <= cpu_pkg::SEL_A;
            src_sel  <= cpu_pkg::SEL_A;
        end else if (state == cpu_pkg::OPER) begin
            load_q   <= load_d;
            is_store <= st;
            case (opc.raw)
                cpu_pkg::OPC_INX, cpu_pkg::OPC_DEX, cpu_pkg::OPC_TAX: dst_sel <= cpu_pkg::SEL_X;
                cpu_pkg::OPC_INY, cpu_pkg::OPC_DEY, cpu_pkg::OPC_TAY: dst_sel <= cpu_pkg::SEL_Y;
                default: dst_sel <= ld ? grp_sel(opc.f.cc) : cpu_pkg::SEL_A;
            endcase
            case (opc.raw)
                cpu_pkg::OPC_INX, cpu_pkg::OPC_DEX, cpu_pkg::OPC_TXA: src_sel <= cpu_pkg::SEL_X;
                cpu_pkg::OPC_INY, cpu_pkg::OPC_DEY, cpu_pkg::OPC_TYA: src_sel <= cpu_pkg::SEL_Y;
                default: begin
                    if (cpxy)
                        src_sel <= opc.f.aaa[0] ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;  // CPX e0
                    else
                        src_sel <= st ? grp_sel(opc.f.cc) : cpu_pkg::SEL_A;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_op  <= cpu_pkg::ALU_PASS;
            ci_mode <= cpu_pkg::CI_ZERO;
            mem_src <= 1'b0;
            a_zero  <= 1'b0;
        end else if (state == cpu_pkg::OPER) begin
            mem_src <= ld || alu || cpxy;   // B from the read bus
            a_zero  <= ld;                  // Loads are 0 + data
            if (alu) begin
                case (opc.f.aaa)
                    3'b000:  alu_op <= cpu_pkg::ALU_OR;
                    3'b001:  alu_op <= cpu_pkg::ALU_AND;
                    3'b010:  alu_op <= cpu_pkg::ALU_EOR;
                    3'b011:  alu_op <= cpu_pkg::ALU_ADD;
                    default: alu_op <= cpu_pkg::ALU_SUB;    // CMP, SBC
                endcase
            end else if (ld || inc) begin
                alu_op <= cpu_pkg::ALU_ADD;
            end else if (cpxy || dec) begin
                alu_op <= cpu_pkg::ALU_SUB;                 // DEX is X + ff
            end else begin
                alu_op <= cpu_pkg::ALU_PASS;
            end
            if (adc_sbc)
                ci_mode <= cpu_pkg::CI_CARRY;
            else if (cmp || cpxy || inc)
                ci_mode <= cpu_pkg::CI_ONE;
            else
                ci_mode <= cpu_pkg::CI_ZERO;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            nz_q  <= 1'b0;
            c_q   <= 1'b0;
            v_q   <= 1'b0;
            clc_q <= 1'b0;
            sec_q <= 1'b0;
        end else if (state == cpu_pkg::OPER) begin
            nz_q  <= load_d || cmp || cpxy;
            c_q   <= adc_sbc || cmp || cpxy;
            v_q   <= adc_sbc;
            clc_q <= (opc.raw == cpu_pkg::OPC_CLC);
            sec_q <= (opc.raw == cpu_pkg::OPC_SEC);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cpu_pkg::RST0;
        end else begin
            case (state)
                cpu_pkg::RST0:   state <= cpu_pkg::RST1;
                cpu_pkg::RST1:   state <= cpu_pkg::DECODE;
                cpu_pkg::DECODE: state <= cpu_pkg::OPER;
                cpu_pkg::OPER: begin
                    if (st)
                        state <= cpu_pkg::ZPWR;
                    else if ((ld || alu) && zp)
                        state <= cpu_pkg::ZPRD;
                    else if (opc.raw == cpu_pkg::OPC_JMP)
                        state <= cpu_pkg::JMP1;
                    else if (branch && cond_true)
                        state <= cpu_pkg::BRA1;
                    else
                        state <= cpu_pkg::DECODE;       // Implied, immediate, NOP
                end
                default:         state <= cpu_pkg::DECODE;
            endcase
        end
    end

    assign load_reg  = load_q && exec;
    assign set_nz    = nz_q && exec;
    assign set_c     = c_q && exec;
    assign set_v     = v_q && exec;
    assign clc       = clc_q && exec;
    assign sec       = sec_q && exec;
    assign cond_code = (state == cpu_pkg::OPER) ? opc.f.aaa : ir.f.aaa;

    assert property (@(posedge clk) disable iff (reset)
        state inside {cpu_pkg::RST0, cpu_pkg::RST1, cpu_pkg::DECODE, cpu_pkg::OPER,
                      cpu_pkg::ZPRD, cpu_pkg::ZPWR, cpu_pkg::JMP1, cpu_pkg::BRA1});

    assert property (@(posedge clk) disable iff (reset) !(is_store && load_reg));

endmodule

//--- hw/cpu_alu.sv
/*
 * Combinational 8-bit ALU.
 * Picks its operands and carry in, then does OR, AND, EOR, add,
 * subtract or pass with carry and signed overflow out.
 */
`timescale 1ns/10ps

module cpu_alu (
    input  cpu_pkg::alu_op_t alu_op,
    input  logic             a_zero,
    input  logic             mem_src,
    input  logic [1:0]       ci_mode,
    input  logic [7:0]       reg_out,
    input  logic [7:0]       rdata,
    input  logic             carry,
    output logic [7:0]       result,
    output logic             co,
    output logic             vo
);

    logic [7:0] ai;
    logic [7:0] bi;
    logic       ci;
    logic [7:0] bx;                         // B after inversion for SUB
    logic [8:0] sum;

    assign ai = a_zero ? 8'h00 : reg_out;
    assign bi = mem_src ? rdata : 8'h00;    // Zero for INX, DEX and friends

    always_comb begin
        case (ci_mode)
            cpu_pkg::CI_ONE:   ci = 1'b1;
            cpu_pkg::CI_CARRY: ci = carry;
            default:           ci = 1'b0;
        endcase
    end

    assign bx  = (alu_op == cpu_pkg::ALU_SUB) ? ~bi : bi;
    assign sum = {1'b0, ai} + {1'b0, bx} + {8'h00, ci};
    assign co  = sum[8];                    // Borrow inverted on SUB
    assign vo  = (ai[7] == bx[7]) && (sum[7] != ai[7]);

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_OR:  result = ai | bi;
            cpu_pkg::ALU_AND: result = ai & bi;
            cpu_pkg::ALU_EOR: result = ai ^ bi;
            cpu_pkg::ALU_ADD,
            cpu_pkg::ALU_SUB: result = sum[7:0];
            default:          result = ai;   // Transfers
        endcase
    end

endmodule

//--- hw/cpu_regs.sv
/*
 * Register unit.
 * Holds A, X, Y and the N, V, Z, C flags, drives the selected source
 * register and tests the branch condition.
 */
`timescale 1ns/10ps

module cpu_regs (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        result,
    input  logic              co,
    input  logic              vo,
    input  logic              load_reg,
    input  cpu_pkg::reg_sel_t dst_sel,
    input  cpu_pkg::reg_sel_t src_sel,
    input  logic              set_nz,
    input  logic              set_c,
    input  logic              set_v,
    input  logic              clc,
    input  logic              sec,
    input  logic [2:0]        cond_code,
    output logic [7:0]        reg_out,
    output logic              carry,
    output logic              cond_true
);

    logic [7:0] a;
    logic [7:0] x;
    logic [7:0] y;
    logic       n;
    logic       v;
    logic       z;
    logic       c;

    always_ff @(posedge clk) begin
        if (load_reg) begin
            case (dst_sel)
                cpu_pkg::SEL_X: x <= result;
                cpu_pkg::SEL_Y: y <= result;
                default:        a <= result;
            endcase
        end
    end

    // Compares land here with set_nz but no load_reg
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            n <= 1'b0;
            v <= 1'b0;
            z <= 1'b0;
            c <= 1'b0;
        end else begin
            if (set_nz) begin
                n <= result[7];
                z <= (result == 8'h00);
            end
            if (set_c)
                c <= co;
            else if (sec)
                c <= 1'b1;
            else if (clc)
                c <= 1'b0;
            if (set_v)
                v <= vo;
        end
    end

    always_comb begin
        case (src_sel)
            cpu_pkg::SEL_X: reg_out = x;
            cpu_pkg::SEL_Y: reg_out = y;
            default:        reg_out = a;
        endcase
    end

    assign carry = c;

    always_comb begin
        case (cond_code)
            3'b000:  cond_true = ~n;        // BPL
            3'b001:  cond_true = n;         // BMI
            3'b010:  cond_true = ~v;        // BVC
            3'b011:  cond_true = v;         // BVS
            3'b100:  cond_true = ~c;        // BCC
            3'b101:  cond_true = c;         // BCS
            3'b110:  cond_true = ~z;        // BNE
            default: cond_true = z;         // BEQ
        endcase
    end

    assert property (@(posedge clk) disable iff (reset)
        load_reg |-> dst_sel inside {cpu_pkg::SEL_A, cpu_pkg::SEL_X, cpu_pkg::SEL_Y});

endmodule

//--- hw/cpu_addr.sv
/*
 * Address unit.
 * Program counter with branch and jump loading, the address bus mux
 * and the write data path.
 */
`timescale 1ns/10ps

module cpu_addr (
    input  logic            clk,
    input  logic            reset,
    input  cpu_pkg::state_t state,
    input  logic [7:0]      rdata,
    input  logic [7:0]      reg_out,
    input  logic            cond_true,
    input  logic            is_store,
    output logic [15:0]     addr,
    output logic [7:0]      wdata,
    output logic            we
);

    logic [15:0] pc;
    logic [7:0]  opl;                       // Vector or jump low byte
    logic        jump_q;                    // Target high byte due on rdata
    logic        one_byte;                  // Columns x8 and xa have no operand

    assign one_byte = (rdata[3:0] == 4'h8) || (rdata[3:0] == 4'ha);

    always_comb begin
        case (state)
            cpu_pkg::RST0:   addr = cpu_pkg::VEC_RESET_LO;
            cpu_pkg::RST1:   addr = cpu_pkg::VEC_RESET_HI;
            cpu_pkg::ZPRD,
            cpu_pkg::ZPWR:   addr = {cpu_pkg::ZEROPAGE, rdata};
            cpu_pkg::DECODE: addr = jump_q ? {rdata, opl} : pc;
            default:         addr = pc;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc     <= 16'h0000;
            jump_q <= 1'b0;
        end else begin
            jump_q <= (state == cpu_pkg::RST1) || (state == cpu_pkg::JMP1);
            case (state)
                cpu_pkg::DECODE: pc <= addr + 16'd1;   // Past the opcode
                cpu_pkg::OPER:   pc <= one_byte ? pc : pc + 16'd1;
                cpu_pkg::BRA1:   pc <= cond_true ? pc + {{8{rdata[7]}}, rdata} : pc;
                default:         pc <= pc;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::RST1 || state == cpu_pkg::JMP1)
            opl <= rdata;
    end

    assign wdata = reg_out;
    assign we    = (state == cpu_pkg::ZPWR) && is_store;

    // A store hands straight over to the next opcode fetch at the PC
    assert property (@(posedge clk) disable iff (reset)
        we |=> (state == cpu_pkg::DECODE) && (addr == pc));

endmodule

//--- hw/cpu.sv
/*
 * Reduced 6502-style core top level.
 * Joins decoder, ALU, register and address units to a memory bus
 * with separate read and write data.
 */
`timescale 1ns/10ps

module cpu (
    input  logic        clk,
    input  logic        reset,
    output logic [15:0] addr,
    input  logic [7:0]  rdata,
    output logic [7:0]  wdata,
    output logic        we
);

    cpu_pkg::state_t   state;
    cpu_pkg::alu_op_t  alu_op;
    cpu_pkg::reg_sel_t src_sel;
    cpu_pkg::reg_sel_t dst_sel;
    logic              load_reg;
    logic              mem_src;
    logic              a_zero;
    logic [1:0]        ci_mode;
    logic              set_nz;
    logic              set_c;
    logic              set_v;
    logic              clc;
    logic              sec;
    logic              is_store;
    logic [2:0]        cond_code;
    logic [7:0]        result;
    logic              co;
    logic              vo;
    logic [7:0]        reg_out;
    logic              carry;
    logic              cond_true;

    cpu_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .rdata     (rdata),
        .cond_true (cond_true),
        .state     (state),
        .alu_op    (alu_op),
        .src_sel   (src_sel),
        .dst_sel   (dst_sel),
        .load_reg  (load_reg),
        .mem_src   (mem_src),
        .a_zero    (a_zero),
        .ci_mode   (ci_mode),
        .set_nz    (set_nz),
        .set_c     (set_c),
        .set_v     (set_v),
        .clc       (clc),
        .sec       (sec),
        .is_store  (is_store),
        .cond_code (cond_code)
    );

    cpu_alu u_alu (
        .alu_op  (alu_op),
        .a_zero  (a_zero),
        .mem_src (mem_src),
        .ci_mode (ci_mode),
        .reg_out (reg_out),
        .rdata   (rdata),
        .carry   (carry),
        .result  (result),
        .co      (co),
        .vo      (vo)
    );

    cpu_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .result    (result),
        .co        (co),
        .vo        (vo),
        .load_reg  (load_reg),
        .dst_sel   (dst_sel),
        .src_sel   (src_sel),
        .set_nz    (set_nz),
        .set_c     (set_c),
        .set_v     (set_v),
        .clc       (clc),
        .sec       (sec),
        .cond_code (cond_code),
        .reg_out   (reg_out),
        .carry     (carry),
        .cond_true (cond_true)
    );

    cpu_addr u_addr (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .rdata     (rdata),
        .reg_out   (reg_out),
        .cond_true (cond_true),
        .is_store  (is_store),
        .addr      (addr),
        .wdata     (wdata),
        .we        (we)
    );

endmodule

//--- testbench/tb_cpu.sv
/*
 * Testbench for the reduced 6502-style core.
 * Byte memory model, directed programs for loads, stores, ALU ops,
 * register moves, branches and JMP, checked at zero-page stores.
 */
`timescale 1ns/10ps

module tb_cpu;

    localparam int CLK_PERIOD = 4;
    localparam int N_LDST     = 8;
    localparam int N_ALU      = 20;
    localparam int N_REG      = 4;
    localparam int N_BR       = 32;
    localparam int N_JMP      = 4;
    localparam int N_TESTS    = 1 + N_LDST + N_ALU + N_REG + N_BR + N_JMP;
    localparam logic [15:0] ORG = 16'h0300;     // Start of most programs

    logic        clk;
    logic        reset;
    logic [15:0] addr;
    logic [7:0]  rdata = 8'h00;
    logic [7:0]  wdata;
    logic        we;

    logic [7:0]  mem [0:65535];
    logic [15:0] rd_addr = 16'h0000;            // Address taken at the rising edge
    logic [15:0] load_ptr;                      // Next free byte of the program
    integer      seed;

    cpu u_dut (
        .clk   (clk),
        .reset (reset),
        .addr  (addr),
        .rdata (rdata),
        .wdata (wdata),
        .we    (we)
    );

    always @(posedge clk) begin
        rd_addr <= addr;
        if (we)
            mem[addr] <= wdata;
    end

    always @(negedge clk)
        rdata <= mem[rd_addr];                  // Read data changes on the falling edge

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Generous budget of 200 cycles per test
    initial begin
        #(N_TESTS * 200 * CLK_PERIOD);
        $display("Timeout: an expected store never arrived in time");
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        rand_byte = r[7:0];
    endfunction

    task automatic compare(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic put_byte(input logic [7:0] b);
        mem[load_ptr] = b;
        load_ptr = load_ptr + 16'd1;
    endtask

    // Core held in reset while memory is rewritten
    task automatic begin_program(input logic [15:0] org);
        @(negedge clk);
        reset = 1'b1;
        load_ptr = org;
    endtask

    task automatic park();
        logic [15:0] here;
        here = load_ptr;
        put_byte(8'h4c);                        // JMP to itself
        put_byte(here[7:0]);
        put_byte(here[15:8]);
    endtask

    task automatic launch(input logic [15:0] org);
        mem[16'hfffc] = org[7:0];
        mem[16'hfffd] = org[15:8];
        repeat (10) @(negedge clk);
        reset = 1'b0;
        repeat (3) @(posedge clk);              // RST0, RST1, then first opcode fetch
        compare(addr, org, "address after reset vector");
    endtask

    task automatic wait_store(input logic [7:0] zp, output logic [7:0] val);
        do
            @(posedge clk);
        while (!(we && addr == {8'h00, zp}));
        val = wdata;
    endtask

    // LDA, LDX, LDY in immediate or zero-page form
    function automatic logic [7:0] load_opcode(input int r, input logic zp);
        case (r)
            0:       load_opcode = zp ? 8'ha5 : 8'ha9;
            1:       load_opcode = zp ? 8'ha6 : 8'ha2;
            default: load_opcode = zp ? 8'ha4 : 8'ha0;
        endcase
    endfunction

    task automatic vector_fetch();
        logic [15:0] org;
        org = 16'h2000 | ({rand_byte(), rand_byte()} & 16'h1fff);
        begin_program(org);
        park();
        launch(org);
    endtask

    task automatic load_store();
        logic [7:0] data [0:2];
        logic [7:0] t;
        logic [7:0] got;
        begin_program(ORG);
        for (int r = 0; r < 3; r++) begin
            data[r] = rand_byte();
            t = rand_byte();
            put_byte(load_opcode(r, t[0]));
            if (t[0]) begin                     // Data parked at 10..12
                put_byte(8'h10 + 8'(r));
                mem[16'h0010 + r] = data[r];
            end else begin
                put_byte(data[r]);
            end
        end
        for (int r = 0; r < 3; r++) begin
            put_byte(r == 0 ? 8'h85 : (r == 1 ? 8'h86 : 8'h84));   // STA, STX, STY
            put_byte(8'h20 + 8'(r));
        end
        park();
        launch(ORG);
        for (int r = 0; r < 3; r++) begin
            wait_store(8'h20 + 8'(r), got);
            compare(got, data[r], "stored register");
        end
    endtask

    task automatic alu_op_store();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] t;
        logic [7:0] exp;
        logic [7:0] got;
        logic [2:0] aaa;
        logic       cin;
        a   = rand_byte();
        b   = rand_byte();
        t   = rand_byte();
        cin = t[0];
        case (t[7:4] % 5)
            0: begin
                aaa = 3'd0;                     // ORA
                exp = a | b;
            end
            1: begin
                aaa = 3'd1;                     // AND
                exp = a & b;
            end
            2: begin
                aaa = 3'd2;                     // EOR
                exp = a ^ b;
            end
            3: begin
                aaa = 3'd3;                     // ADC
                exp = a + b + {7'd0, cin};
            end
            default: begin
                aaa = 3'd7;                     // SBC, borrow is !C
                exp = a - b - {7'd0, !cin};
            end
        endcase
        begin_program(ORG);
        put_byte(8'ha9);
        put_byte(a);
        put_byte(cin ? 8'h38 : 8'h18);          // SEC or CLC
        if (t[1]) begin
            put_byte({aaa, 5'b00101});          // Zero-page form
            put_byte(8'h30);
            mem[16'h0030] = b;
        end else begin
            put_byte({aaa, 5'b01001});          // Immediate form
            put_byte(b);
        end
        put_byte(8'h85);
        put_byte(8'h31);
        park();
        launch(ORG);
        wait_store(8'h31, got);
        compare(got, exp, "ALU result in A");
    endtask

    task automatic register_moves();
        logic [7:0] a;
        logic [7:0] a_inc;
        logic [7:0] got;
        a     = rand_byte();
        a_inc = a + 8'd1;
        begin_program(ORG);
        put_byte(8'ha9);
        put_byte(a);
        put_byte(8'haa);                        // TAX
        put_byte(8'he8);                        // INX
        put_byte(8'h8a);                        // TXA
        put_byte(8'ha8);                        // TAY
        put_byte(8'h88);                        // DEY
        put_byte(8'h98);                        // TYA
        put_byte(8'h85);
        put_byte(8'h40);
        put_byte(8'h86);
        put_byte(8'h41);
        park();
        launch(ORG);
        wait_store(8'h40, got);
        compare(got, a, "A after +1 -1");
        wait_store(8'h41, got);
        compare(got, a_inc, "X after INX");
    endtask

    task automatic flag_branch();
        logic [7:0] a;
        logic [7:0] x;
        logic [7:0] v;
        logic [7:0] r;
        logic [7:0] t;
        logic [7:0] got;
        int         u_sum;
        int         s_sum;
        logic       n;
        logic       z;
        logic       c;
        logic       ov;
        logic       taken;
        a = rand_byte();
        x = rand_byte();
        v = rand_byte();
        t = rand_byte();
        if (t[5]) begin                         // Steer toward equal or zero results
            case (t[1:0])
                2'd0:    v = a;
                2'd1:    v = x;
                2'd2:    v = 8'h00 - a;
                default: v = 8'h00;
            endcase
        end
        c  = 1'b0;                              // CLC runs first, V cleared by reset
        ov = 1'b0;
        case (t[1:0])
            2'd0: begin
                r = a - v;                      // CMP
                c = (a >= v);
            end
            2'd1: begin
                r = x - v;                      // CPX
                c = (x >= v);
            end
            2'd2: begin
                u_sum = int'(a) + int'(v);      // ADC with C clear
                s_sum = int'($signed(a)) + int'($signed(v));
                r     = u_sum[7:0];
                c     = (u_sum > 255);
                ov    = (s_sum > 127) || (s_sum < -128);    // Signed sum out of range
            end
            default: r = v;                     // LDA
        endcase
        n = r[7];
        z = (r == 8'h00);
        case (t[4:2])
            3'd0:    taken = !n;                // BPL
            3'd1:    taken = n;                 // BMI
            3'd2:    taken = !ov;               // BVC
            3'd3:    taken = ov;                // BVS
            3'd4:    taken = !c;                // BCC
            3'd5:    taken = c;                 // BCS
            3'd6:    taken = !z;                // BNE
            default: taken = z;                 // BEQ
        endcase
        begin_program(ORG);
        put_byte(8'ha9);
        put_byte(a);
        put_byte(8'ha2);
        put_byte(x);
        put_byte(8'h18);
        case (t[1:0])
            2'd0:    put_byte(8'hc9);
            2'd1:    put_byte(8'he0);
            2'd2:    put_byte(8'h69);
            default: put_byte(8'ha9);
        endcase
        put_byte(v);
        put_byte({t[4:2], 5'b10000});           // Branch over the next 7 bytes
        put_byte(8'h07);
        put_byte(8'ha9);                        // Fall-through marker
        put_byte(8'h55);
        put_byte(8'h85);
        put_byte(8'h60);
        park();
        put_byte(8'ha9);                        // Taken marker
        put_byte(8'haa);
        put_byte(8'h85);
        put_byte(8'h60);
        park();
        launch(ORG);
        wait_store(8'h60, got);
        compare(got, taken ? 8'haa : 8'h55, "branch marker");
    endtask

    task automatic jump_absolute();
        logic [15:0] target;
        logic [7:0]  m;
        logic [7:0]  got;
        m      = rand_byte();
        target = 16'h4000 | ({rand_byte(), rand_byte()} & 16'h3fff);
        begin_program(ORG);
        put_byte(8'h4c);
        put_byte(target[7:0]);
        put_byte(target[15:8]);
        put_byte(8'ha9);                        // Skipped code stores the inverse
        put_byte(~m);
        put_byte(8'h85);
        put_byte(8'h70);
        park();
        load_ptr = target;
        put_byte(8'ha9);
        put_byte(m);
        put_byte(8'h85);
        put_byte(8'h70);
        park();
        launch(ORG);
        wait_store(8'h70, got);
        compare(got, m, "marker after JMP");
    endtask

    initial begin
        reset = 1'b1;
        seed  = 32'hdd0b_9093;
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3c;   // Fill depends on both address bytes
        vector_fetch();
        repeat (N_LDST) load_store();
        repeat (N_ALU) alu_op_store();
        repeat (N_REG) register_moves();
        repeat (N_BR) flag_branch();
        repeat (N_JMP) jump_absolute();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- filelist.f
hw/cpu_pkg.sv
hw/cpu_decode.sv
hw/cpu_alu.sv
hw/cpu_regs.sv
hw/cpu_addr.sv
hw/cpu.sv
testbench/tb_cpu.sv
